/* wires.sv */
package wires;

  // word-level request toward memory
  typedef struct packed {
    logic        valid;
    logic        instr;  // set for fetches
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // zero for reads
  } mem_in_type;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_out_type;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_t;

  // core-side data request, value in the low bits of wdata
  typedef struct packed {
    logic        valid;
    logic        write;
    mem_size_t   size;
    logic        unsigned_load;
    logic [31:0] addr;
    logic [31:0] wdata;
  } data_req_type;

  typedef struct packed {
    logic [31:0] rdata;  // already extended
    logic        ready;
  } data_rsp_type;

  typedef enum logic {
    owner_instr,
    owner_data
  } owner_t;

endpackage

/* data_align.sv */
`timescale 1ns/1ps

module data_align import wires::*; (
  input  logic         clk,
  input  logic         rst,
  input  data_req_type data_req,
  output data_rsp_type data_rsp,
  output mem_in_type   dmem_req,
  input  mem_out_type  dmem_rsp
);

  logic        pending;
  mem_size_t   size_q;
  logic [1:0]  off_q;
  logic        unsigned_q;
  logic [3:0]  strb;
  logic [31:0] shifted;

  always_comb begin
    case (data_req.size)
      size_byte: strb = 4'b0001 << data_req.addr[1:0];
      size_half: strb = 4'b0011 << data_req.addr[1:0];
      default:   strb = 4'b1111;
    endcase

    dmem_req.valid = data_req.valid;
    dmem_req.instr = 1'b0;
    dmem_req.addr  = {data_req.addr[31:2], 2'b00};
    dmem_req.wstrb = data_req.write ? strb : 4'b0000;
    case (data_req.size)
      size_byte: dmem_req.wdata = {4{data_req.wdata[7:0]}};  // same byte in every lane
      size_half: dmem_req.wdata = {2{data_req.wdata[15:0]}};
      default:   dmem_req.wdata = data_req.wdata;
    endcase
  end

  // return path uses what was latched when the request showed up
  always_ff @(posedge clk) begin
    if (!rst) begin
      pending <= 1'b0;
    end else if (dmem_rsp.ready) begin
      pending <= 1'b0;
    end else if (data_req.valid) begin
      pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (data_req.valid && !pending) begin
      size_q     <= data_req.size;
      off_q      <= data_req.addr[1:0];
      unsigned_q <= data_req.unsigned_load;
    end
  end

  always_comb begin
    shifted = dmem_rsp.rdata >> {off_q, 3'b000};
    case (size_q)
      size_byte: data_rsp.rdata = {{24{shifted[7] & ~unsigned_q}}, shifted[7:0]};
      size_half: data_rsp.rdata = {{16{shifted[15] & ~unsigned_q}}, shifted[15:0]};
      default:   data_rsp.rdata = dmem_rsp.rdata;
    endcase
    data_rsp.ready = dmem_rsp.ready;
  end

  // core holds the request until it sees ready
  a_req_stable: assert property (@(posedge clk) disable iff (!rst)
    data_req.valid && !data_rsp.ready |=> data_req.valid && $stable(data_req));

  a_half_even: assert property (@(posedge clk) disable iff (!rst)
    data_req.valid && data_req.size == size_half |-> !data_req.addr[0]);

endmodule

/* arbiter.sv */
`timescale 1ns/1ps

module arbiter import wires::*; (
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  imem_req,
  output mem_out_type imem_rsp,
  input  mem_in_type  dmem_req,
  output mem_out_type dmem_rsp,
  output mem_in_type  mem_req,
  input  mem_out_type mem_rsp
);

  owner_t access;  // side asking this cycle
  owner_t owner;   // side the response path belongs to

  always_comb begin
    access = dmem_req.valid ? owner_data : owner_instr;  // data wins

    // a data access in flight blocks the memory input until it is answered
    if (owner == owner_data && !mem_rsp.ready) begin
      mem_req = '0;
    end else if (access == owner_data) begin
      mem_req = dmem_req;
    end else begin
      mem_req = imem_req;
    end
  end

  always_comb begin
    if (owner == owner_instr) begin
      imem_rsp.rdata = mem_rsp.rdata;
      imem_rsp.ready = mem_rsp.ready;
      dmem_rsp.rdata = 32'h0;
      dmem_rsp.ready = 1'b0;
    end else begin
      imem_rsp.rdata = 32'h0;
      imem_rsp.ready = 1'b0;
      dmem_rsp.rdata = mem_rsp.rdata;
      dmem_rsp.ready = mem_rsp.ready;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      owner <= owner_instr;
    end else begin
      case (owner)
        owner_instr: begin
          if (access == owner_data) begin
            owner <= owner_data;
          end
        end
        owner_data: begin
          // the data request answered in this cycle no longer counts as pending,
          // so the next fetch can follow right after it
          if (mem_rsp.ready) begin
            owner <= owner_instr;
          end
        end
        default: owner <= owner_instr;
      endcase
    end
  end

  // an answer goes back only to the side whose request is still held
  a_one_port: assert property (@(posedge clk) disable iff (!rst)
    mem_rsp.ready |-> (dmem_rsp.ready ? dmem_req.valid : imem_req.valid && !dmem_req.valid));

endmodule

/* sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl import wires::*; #(
  parameter int depth       = 256,
  parameter int wait_states = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  mem_req,
  output mem_out_type mem_rsp
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = (wait_states > 1) ? $clog2(wait_states) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_resp
  } state_t;

  state_t        state;
  logic [cw-1:0] cnt;
  logic [31:0]   addr_q;
  logic [31:0]   wdata_q;
  logic [3:0]    wstrb_q;
  logic [aw-1:0] idx;
  logic [31:0]   mem [depth];

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = 32'h0;
    end
  end

  assign idx = aw'(addr_q[31:2] % 30'(depth));  // wraps at depth words

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (mem_req.valid) begin
            state <= (wait_states == 0) ? st_resp : st_wait;
            cnt   <= '0;
          end
        end
        st_wait: begin
          if (cnt == cw'(wait_states - 1)) begin
            state <= st_resp;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= st_idle;  // st_resp lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && mem_req.valid) begin
      addr_q  <= mem_req.addr;
      wdata_q <= mem_req.wdata;
      wstrb_q <= mem_req.wstrb;
    end
    if (state == st_resp) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_q[b]) mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
      end
    end
  end

  assign mem_rsp.rdata = mem[idx];  // old word until the write lands
  assign mem_rsp.ready = (state == st_resp);

  // a single ready pulse wait_states + 1 cycles after the request is latched
  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    mem_rsp.ready |-> !$past(mem_rsp.ready) && $past(state, wait_states + 1) == st_idle);

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import wires::*; #(
  parameter int depth       = 256,
  parameter int wait_states = 2
) (
  input  logic         clk,
  input  logic         rst,
  input  mem_in_type   imem_req,
  output mem_out_type  imem_rsp,
  input  data_req_type data_req,
  output data_rsp_type data_rsp
);

  mem_in_type  dmem_req;
  mem_out_type dmem_rsp;
  mem_in_type  mem_req;
  mem_out_type mem_rsp;

  data_align i_data_align (
    .clk      (clk),
    .rst      (rst),
    .data_req (data_req),
    .data_rsp (data_rsp),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp)
  );

  arbiter i_arbiter (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  sram_ctrl #(
    .depth       (depth),
    .wait_states (wait_states)
  ) i_sram_ctrl (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // active low, released just after a rising edge
  initial begin
    rst = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem import wires::*; ();

  localparam int depth       = 256;
  localparam int wait_states = 2;
  localparam int n_trans     = 600;
  localparam int max_wait    = 20;
  localparam int cycle_limit = n_trans * max_wait;
  localparam int mem_bytes   = depth * 4;

  logic         clk;
  logic         rst;
  mem_in_type   imem_req;
  mem_out_type  imem_rsp;
  data_req_type data_req;
  data_rsp_type data_rsp;

  logic [31:0] rng_state;
  logic [7:0]  model_mem [mem_bytes];  // byte-wide reference memory
  int          value_errors;
  int          timing_errors;
  int          timeout_errors;
  int          cycles;

  tb_clock #(
    .period_ns    (8),
    .reset_cycles (16)
  ) i_clock (
    .clk (clk),
    .rst (rst)
  );

  mem_subsystem #(
    .depth       (depth),
    .wait_states (wait_states)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .data_req (data_req),
    .data_rsp (data_rsp)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [9:0] a;
    a = {addr[9:2], 2'b00};
    return {model_mem[a + 10'd3], model_mem[a + 10'd2], model_mem[a + 10'd1], model_mem[a]};
  endfunction

  function automatic logic [31:0] expect_load(input mem_size_t size, input logic uns,
                                              input logic [31:0] addr);
    logic [9:0]  a;
    logic [7:0]  b;
    logic [15:0] h;
    a = addr[9:0];
    case (size)
      size_byte: begin
        b = model_mem[a];
        return uns ? {24'h0, b} : {{24{b[7]}}, b};
      end
      size_half: begin
        h = {model_mem[a + 10'd1], model_mem[a]};
        return uns ? {16'h0, h} : {{16{h[15]}}, h};
      end
      default: return model_word(addr);
    endcase
  endfunction

  task automatic model_store(input mem_size_t size, input logic [31:0] addr,
                             input logic [31:0] wdata);
    logic [9:0] a;
    int         n;
    a = addr[9:0];
    case (size)
      size_byte: n = 1;
      size_half: n = 2;
      default:   n = 4;
    endcase
    for (int i = 0; i < n; i++) begin
      model_mem[a + 10'(i)] = wdata[8*i +: 8];
    end
  endtask

  // one idle cycle, nothing asked so nothing may answer
  task automatic idle_cycle();
    imem_req.valid = 1'b0;
    data_req.valid = 1'b0;
    @(negedge clk);
    if (imem_rsp.ready || data_rsp.ready) begin
      $display("FAILED at %0t: ready high with no request pending", $time);
      timing_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // counts cycles from valid to ready, sampling between edges
  task automatic wait_ready(input owner_t port, output logic seen, output logic [31:0] rdata);
    int   count;
    logic own_ready;
    logic other_ready;
    seen  = 1'b0;
    rdata = 32'h0;
    count = 0;
    while (!seen && count < max_wait) begin
      @(negedge clk);
      count++;
      own_ready   = (port == owner_instr) ? imem_rsp.ready : data_rsp.ready;
      other_ready = (port == owner_instr) ? data_rsp.ready : imem_rsp.ready;
      if (other_ready) begin
        $display("FAILED at %0t: ready on the port without a request (%s pending)",
                 $time, port.name());
        timing_errors++;
      end
      if (own_ready) begin
        seen  = 1'b1;
        rdata = (port == owner_instr) ? imem_rsp.rdata : data_rsp.rdata;
        if (count != wait_states + 2) begin
          $display("FAILED at %0t: %s ready after %0d cycles, expected %0d",
                   $time, port.name(), count, wait_states + 2);
          timing_errors++;
        end
      end
    end
    if (!seen) begin
      $display("The %s port gave no ready within %0d cycles, request dropped at time %0t",
               port.name(), max_wait, $time);
      timeout_errors++;
    end
    @(posedge clk);  // request is held through the edge that sees ready
    #1;
  endtask

  task automatic issue(input owner_t port, input logic write, input mem_size_t size,
                       input logic uns, input logic [31:0] addr, input logic [31:0] wdata);
    logic        seen;
    logic [31:0] got;
    logic [31:0] exp;
    imem_req = '0;
    data_req = '0;
    if (port == owner_instr) begin
      imem_req.valid = 1'b1;
      imem_req.instr = 1'b1;
      imem_req.addr  = addr;
    end else begin
      data_req.valid         = 1'b1;
      data_req.write         = write;
      data_req.size          = size;
      data_req.unsigned_load = uns;
      data_req.addr          = addr;
      data_req.wdata         = wdata;
    end
    wait_ready(port, seen, got);
    if (seen) begin
      if (port == owner_instr) begin
        exp = model_word(addr);
        if (got !== exp) begin
          $display("FAILED at %0t: fetch at 0x%03h returned 0x%08h, expected 0x%08h",
                   $time, addr, got, exp);
          value_errors++;
        end
      end else if (write) begin
        model_store(size, addr, wdata);
      end else begin
        exp = expect_load(size, uns, addr);
        if (got !== exp) begin
          $display("FAILED at %0t: %s load (unsigned %0b) at 0x%03h returned 0x%08h, expected 0x%08h",
                   $time, size.name(), uns, addr, got, exp);
          value_errors++;
        end
      end
    end
  endtask

  task automatic run_one();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    owner_t      port;
    mem_size_t   size;
    r     = next_rand();
    wdata = next_rand();
    port  = (r[2:0] < 3'd3) ? owner_instr : owner_data;  // about 3 in 8 are fetches
    // most accesses hit a small window so stores and loads overlap
    addr  = (r[4:3] != 2'b00) ? {26'h0, r[10:5]} : {22'h0, r[14:5]};
    case (r[18:17])
      2'd0:    size = size_byte;
      2'd1:    size = size_half;
      default: size = size_word;
    endcase
    if (port == owner_instr || size == size_word) begin
      addr[1:0] = 2'b00;
    end else if (size == size_half) begin
      addr[0] = 1'b0;
    end
    issue(port, r[15], size, r[16], addr, wdata);
    if (r[20:19] == 2'b00) idle_cycle();  // otherwise the next request follows at once
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped: cycle limit of %0d reached before the tests finished", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    imem_req       = '0;
    data_req       = '0;
    rng_state      = 32'd63320;
    value_errors   = 0;
    timing_errors  = 0;
    timeout_errors = 0;
    for (int i = 0; i < mem_bytes; i++) begin
      model_mem[10'(i)] = 8'h00;
    end
    @(posedge rst);
    @(posedge clk);
    #1;
    repeat (4) idle_cycle();

    // untouched words read back as zero
    for (int i = 0; i < 4; i++) begin
      issue(owner_instr, 1'b0, size_word, 1'b0, 32'h3f0 + 32'(4 * i), 32'h0);
    end
    // store then fetch with no gap
    issue(owner_data, 1'b1, size_word, 1'b0, 32'h80, 32'hcafe_f00d);
    issue(owner_instr, 1'b0, size_word, 1'b0, 32'h80, 32'h0);
    issue(owner_data, 1'b1, size_byte, 1'b0, 32'h85, 32'h0000_00a7);
    issue(owner_data, 1'b0, size_byte, 1'b0, 32'h85, 32'h0);
    issue(owner_data, 1'b0, size_byte, 1'b1, 32'h85, 32'h0);
    issue(owner_data, 1'b1, size_half, 1'b0, 32'h86, 32'h0000_9c31);
    issue(owner_data, 1'b0, size_half, 1'b0, 32'h86, 32'h0);
    issue(owner_data, 1'b0, size_half, 1'b1, 32'h86, 32'h0);
    issue(owner_data, 1'b0, size_word, 1'b0, 32'h84, 32'h0);
    issue(owner_instr, 1'b0, size_word, 1'b0, 32'h84, 32'h0);

    for (int t = 0; t < n_trans; t++) begin
      run_one();
    end

    repeat (2) idle_cycle();
    $display("errors: value %0d, timing %0d, timeout %0d",
             value_errors, timing_errors, timeout_errors);
    if (value_errors + timing_errors + timeout_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
wires.sv
data_align.sv
arbiter.sv
sram_ctrl.sv
mem_subsystem.sv
tb_clock.sv
tb_mem_subsystem.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mem_subsystem
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: compile run clean

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides pass or fail, not the simulator's exit status
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
